// File: fb_cfg_pkg.sv
/* Configuration types */

`include "fb_defines.svh"

package fb_cfg_pkg;

    //////////////////////////////////////////////////
    // Screen configuration
    //////////////////////////////////////////////////

    // Active resolution in pixels per axis
    // Zero on either axis means an empty screen
    typedef struct packed {
        fb_frag_pkg::xpos_t x;
        fb_frag_pkg::ypos_t y;
    } res_t;

    // Scissor rectangle with exclusive upper bounds
    // Passes when x0 <= x < x1 and y0 <= y < y1
    typedef struct packed {
        fb_frag_pkg::xpos_t x0;
        fb_frag_pkg::ypos_t y0;
        fb_frag_pkg::xpos_t x1;
        fb_frag_pkg::ypos_t y1;
    } scissor_t;

    // Clear color shares the pixel layout of the framebuffer
    typedef fb_frag_pkg::pixel_t clear_color_t;

endpackage

// File: fb_clear.sv
/* Framebuffer clear generator */

`include "fb_defines.svh"

module fb_clear (
    input  logic                   aclk,
    input  logic                   resetn,

    // Configuration
    input  fb_cfg_pkg::res_t       res,
    input  fb_cfg_pkg::clear_color_t clear_color,

    // Fragments from the pixel pipeline
    frag_if.sink                   s_frag,

    // Fragments toward the writer
    frag_if.source                 m_frag,

    // Start pulse and idle level
    input  logic                   apply,
    output logic                   applied
);

    //////////////////////////////////////////////////
    // Counters and decode
    //////////////////////////////////////////////////

    fb_frag_pkg::clear_state_e state;

    fb_frag_pkg::xpos_t x_cnt;
    fb_frag_pkg::ypos_t y_cnt;
    fb_frag_pkg::addr_t addr_cnt;

    fb_frag_pkg::xpos_t x_max;
    fb_frag_pkg::ypos_t y_top;

    logic               run;
    logic               x_end;
    logic               y_end;
    logic               res_ok;
    fb_frag_pkg::frag_t clr_frag;

    assign run = (state == fb_frag_pkg::CLR_RUN);

    // Pipeline is only released while no clear is in flight
    assign applied = !run;

    // Last column and top row of the configured screen
    assign x_max = res.x - 1'b1;
    assign y_top = res.y - 1'b1;

    assign x_end = (x_cnt == x_max);
    assign y_end = (y_cnt == '0);

    // Empty screen gives nothing to clear
    assign res_ok = (res.x != '0) && (res.y != '0);

    // Generated fragment always carries the strobe
    assign clr_frag = '{
        data: clear_color,
        strb: 1'b1,
        addr: addr_cnt,
        xpos: x_cnt,
        ypos: y_cnt
    };

    //////////////////////////////////////////////////
    // Output multiplexer
    //////////////////////////////////////////////////

    always_comb
    begin
        if (run)
        begin
            // Clear owns the bus, pipeline stalls
            m_frag.valid = 1'b1;
            m_frag.last  = x_end && y_end;
            m_frag.frag  = clr_frag;
            s_frag.ready = 1'b0;
        end
        else
        begin
            // Straight pass-through in zero cycles
            m_frag.valid = s_frag.valid;
            m_frag.last  = s_frag.last;
            m_frag.frag  = s_frag.frag;
            s_frag.ready = m_frag.ready;
        end
    end

    //////////////////////////////////////////////////
    // Scan sequence
    //////////////////////////////////////////////////

    // Scan starts at the top row and walks down to y = 0
    // Address runs up from 0 in the same order
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state    <= fb_frag_pkg::CLR_IDLE;
            x_cnt    <= '0;
            y_cnt    <= '0;
            addr_cnt <= '0;
        end
        else
        begin
            case (state)
                fb_frag_pkg::CLR_IDLE:
                begin
                    if (apply && res_ok)
                    begin
                        state    <= fb_frag_pkg::CLR_RUN;
                        x_cnt    <= '0;
                        y_cnt    <= y_top;
                        addr_cnt <= '0;
                    end
                end
                fb_frag_pkg::CLR_RUN:
                begin
                    // Counters hold under back-pressure
                    if (m_frag.ready)
                    begin
                        addr_cnt <= addr_cnt + 1'b1;
                        if (x_end)
                        begin
                            x_cnt <= '0;
                            // Bottom row done ends the clear
                            if (y_end)
                                state <= fb_frag_pkg::CLR_IDLE;
                            else
                                y_cnt <= y_cnt - 1'b1;
                        end
                        else
                        begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                end
                default:
                begin
                    state <= fb_frag_pkg::CLR_IDLE;
                end
            endcase
        end
    end

endmodule

// File: fb_defines.svh
/* Framebuffer size macros */

`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// Framebuffer word address
// Wide enough to index every word of the memory
`define FB_ADDR_WIDTH 12

// Screen coordinates
// Largest resolution per axis is 127
`define FB_X_WIDTH 7
`define FB_Y_WIDTH 7

// One pixel in RGB565 layout
`define FB_PIXEL_WIDTH 16

// Number of pixel words in the on-chip framebuffer
// Must match 2 ** FB_ADDR_WIDTH
`define FB_MEM_DEPTH 4096

`endif

// File: fb_frag_pkg.sv
/* Fragment types */

`include "fb_defines.svh"

package fb_frag_pkg;

    //////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////

    // Color value written into the framebuffer
    typedef logic [`FB_PIXEL_WIDTH-1:0] pixel_t;

    // Linear word address in the framebuffer
    typedef logic [`FB_ADDR_WIDTH-1:0] addr_t;

    // Screen position, origin at the bottom left
    typedef logic [`FB_X_WIDTH-1:0] xpos_t;
    typedef logic [`FB_Y_WIDTH-1:0] ypos_t;

    //////////////////////////////////////////////////
    // Fragment and clear state
    //////////////////////////////////////////////////

    // One fragment as it travels toward the writer
    // Position is kept next to the address for the scissor test
    typedef struct packed {
        pixel_t data;
        logic   strb;
        addr_t  addr;
        xpos_t  xpos;
        ypos_t  ypos;
    } frag_t;

    // Clear generator states
    typedef enum logic [0:0] {
        CLR_IDLE,
        CLR_RUN
    } clear_state_e;

endpackage

// File: fb_testdata.txt
# Commands: CFG name xres yres color x0 y0 x1 y1 | CLEAR name
# FRAG name x y color strb | READ name x y expected, colors in hex
CFG cfg_full 16 8 1111 0 0 16 8
CLEAR clr_full
READ rd_full_bl 0 0 1111
READ rd_full_tr 15 7 1111
READ rd_full_mid 5 3 1111
CFG cfg_scis 16 8 2222 4 2 12 6
CLEAR clr_scis
READ rd_scis_lo 4 2 2222
READ rd_scis_hi 11 5 2222
READ rd_scis_left 3 2 1111
READ rd_scis_right 12 5 1111
READ rd_scis_below 4 1 1111
READ rd_scis_above 4 6 1111
FRAG wr_inside 6 3 abcd 1
READ rd_inside 6 3 abcd
FRAG wr_outside 2 3 5555 1
READ rd_outside 2 3 1111
FRAG wr_nostrb 7 4 6666 0
READ rd_nostrb 7 4 2222
CFG cfg_small 4 4 3333 0 0 16 8
CLEAR clr_small
READ rd_small_bl 0 0 3333
READ rd_small_tr 3 3 3333
CFG cfg_back 16 8 3333 0 0 16 8
READ rd_back_row7 15 7 3333
READ rd_back_row6 0 6 1111
READ rd_back_frag 6 3 abcd
READ rd_back_scis 5 3 2222

// File: fb_top.sv
/* Framebuffer write stage */

`include "fb_defines.svh"

module fb_top (
    input  logic                       aclk,
    input  logic                       resetn,

    // Configuration
    input  logic [`FB_X_WIDTH-1:0]     res_x,
    input  logic [`FB_Y_WIDTH-1:0]     res_y,
    input  logic [`FB_PIXEL_WIDTH-1:0] clear_color,
    input  logic [`FB_X_WIDTH-1:0]     scissor_x0,
    input  logic [`FB_Y_WIDTH-1:0]     scissor_y0,
    input  logic [`FB_X_WIDTH-1:0]     scissor_x1,
    input  logic [`FB_Y_WIDTH-1:0]     scissor_y1,

    // Clear control
    input  logic                       clear_apply,
    output logic                       clear_done,

    // Pipeline fragments
    input  logic                       frag_valid,
    output logic                       frag_ready,
    input  logic                       frag_last,
    input  logic [`FB_PIXEL_WIDTH-1:0] frag_data,
    input  logic                       frag_strb,
    input  logic [`FB_ADDR_WIDTH-1:0]  frag_addr,
    input  logic [`FB_X_WIDTH-1:0]     frag_xpos,
    input  logic [`FB_Y_WIDTH-1:0]     frag_ypos,

    // Read-back
    input  logic [`FB_ADDR_WIDTH-1:0]  rd_addr,
    output logic [`FB_PIXEL_WIDTH-1:0] rd_data
);

    fb_cfg_pkg::res_t     res;
    fb_cfg_pkg::scissor_t scissor;

    // Pipeline side and clear-to-writer side
    frag_if pipe_bus ();
    frag_if pix_bus ();

    assign res     = '{x: res_x, y: res_y};
    assign scissor = '{x0: scissor_x0, y0: scissor_y0, x1: scissor_x1, y1: scissor_y1};

    // Pack loose pipeline ports into one fragment
    assign pipe_bus.valid = frag_valid;
    assign pipe_bus.last  = frag_last;
    assign pipe_bus.frag  = '{
        data: frag_data,
        strb: frag_strb,
        addr: frag_addr,
        xpos: frag_xpos,
        ypos: frag_ypos
    };
    assign frag_ready = pipe_bus.ready;

    fb_clear u_clear (
        .aclk        (aclk),
        .resetn      (resetn),
        .res         (res),
        .clear_color (clear_color),
        .s_frag      (pipe_bus),
        .m_frag      (pix_bus),
        .apply       (clear_apply),
        .applied     (clear_done)
    );

    fb_writer u_writer (
        .aclk    (aclk),
        .resetn  (resetn),
        .scissor (scissor),
        .s_frag  (pix_bus),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: fb_writer.sv
/* Framebuffer writer with scissor test */

`include "fb_defines.svh"

module fb_writer (
    input  logic                 aclk,
    input  logic                 resetn,

    // Scissor rectangle
    input  fb_cfg_pkg::scissor_t scissor,

    // Incoming fragments
    frag_if.sink                 s_frag,

    // Read-back port
    input  fb_frag_pkg::addr_t   rd_addr,
    output fb_frag_pkg::pixel_t  rd_data
);

    //////////////////////////////////////////////////
    // Scissor test
    //////////////////////////////////////////////////

    logic ready_q;
    logic accept;
    logic in_x;
    logic in_y;
    logic pass;

    // Held low through reset, open on the edge after release
    always_ff @(posedge aclk)
    begin
        if (!resetn)
            ready_q <= 1'b0;
        else
            ready_q <= 1'b1;
    end

    assign s_frag.ready = ready_q;
    assign accept = s_frag.valid && ready_q;

    // Upper bounds are exclusive
    assign in_x = (s_frag.frag.xpos >= scissor.x0) && (s_frag.frag.xpos < scissor.x1);
    assign in_y = (s_frag.frag.ypos >= scissor.y0) && (s_frag.frag.ypos < scissor.y1);

    // Strobe clear discards the fragment
    assign pass = accept && s_frag.frag.strb && in_x && in_y;

    //////////////////////////////////////////////////
    // Write stage
    //////////////////////////////////////////////////

    logic                wr_en_q;
    fb_frag_pkg::addr_t  wr_addr_q;
    fb_frag_pkg::pixel_t wr_data_q;

    fb_frag_pkg::pixel_t mem [`FB_MEM_DEPTH];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
            wr_en_q <= 1'b0;
        else
            wr_en_q <= pass;
    end

    // Payload captured only for passing fragments
    always_ff @(posedge aclk)
    begin
        if (pass)
        begin
            wr_addr_q <= s_frag.frag.addr;
            wr_data_q <= s_frag.frag.data;
        end
    end

    // Memory lands one edge after acceptance
    always_ff @(posedge aclk)
    begin
        if (wr_en_q)
            mem[wr_addr_q] <= wr_data_q;
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // One cycle latency from rd_addr
    // Same-edge write returns the old word
    always_ff @(posedge aclk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: frag_if.sv
/* Fragment stream interface */

`include "fb_defines.svh"

interface frag_if;

    // Handshake
    // Transfer on an edge where valid and ready are both high
    logic valid;
    logic ready;

    // Marks the final fragment of a clear
    logic last;

    // Payload, held steady while valid waits for ready
    fb_frag_pkg::frag_t frag;

    // Producer side
    modport source (
        output valid,
        output last,
        output frag,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  last,
        input  frag,
        output ready
    );

endinterface

// File: list.f
+incdir+.
fb_frag_pkg.sv
fb_cfg_pkg.sv
frag_if.sv
fb_clear.sv
fb_writer.sv
fb_top.sv
tb_fb_top.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the framebuffer testbench
# Pass or fail is taken from the simulation log

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_fb_top -f list.f -o tb_fb_top_sim \
    && ./obj_dir/tb_fb_top_sim > sim.log 2>&1 \
    || echo "build or simulation stopped early"
cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// File: tb_fb_top.sv
/* Framebuffer write stage testbench */

module tb_fb_top;

    timeunit 1ns;
    timeprecision 1ps;

    logic                aclk;
    logic                resetn;
    fb_frag_pkg::xpos_t  res_x;
    fb_frag_pkg::ypos_t  res_y;
    fb_frag_pkg::pixel_t clear_color;
    fb_frag_pkg::xpos_t  scissor_x0;
    fb_frag_pkg::ypos_t  scissor_y0;
    fb_frag_pkg::xpos_t  scissor_x1;
    fb_frag_pkg::ypos_t  scissor_y1;
    logic                clear_apply;
    logic                clear_done;
    logic                frag_valid;
    logic                frag_ready;
    logic                frag_last;
    fb_frag_pkg::pixel_t frag_data;
    logic                frag_strb;
    fb_frag_pkg::addr_t  frag_addr;
    fb_frag_pkg::xpos_t  frag_xpos;
    fb_frag_pkg::ypos_t  frag_ypos;
    fb_frag_pkg::addr_t  rd_addr;
    fb_frag_pkg::pixel_t rd_data;

    // Current command fields from the data file
    int                  fd;
    string               cmd;
    string               name;
    int                  cfg_x;
    int                  cfg_y;
    int                  sx0;
    int                  sy0;
    int                  sx1;
    int                  sy1;
    int                  a_x;
    int                  a_y;
    int                  a_strb;
    fb_frag_pkg::pixel_t a_color;

    // Resolution in force, used for addressing
    int                  cur_xres;
    int                  cur_yres;

    // Word of the previous read, known while memory is untouched
    fb_frag_pkg::pixel_t prev_read;
    bit                  prev_read_ok;

    int                  watch_cycles;
    bit                  bound_set;
    int                  tests_run;
    int                  tests_failed;
    int                  err_count;
    int                  test_errs;

    fb_top dut (.*);

    always #4 aclk = ~aclk;

    //////////////////////////////////////////////////
    // Checks and reporting
    //////////////////////////////////////////////////

    task automatic check_pixel(input string what, input fb_frag_pkg::pixel_t expected,
                               input fb_frag_pkg::pixel_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s expected %h actual %h", what, expected, actual);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s expected %b actual %b", what, expected, actual);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s", msg);
        err_count++;
        test_errs++;
    endtask

    task automatic end_test(input string what);
        tests_run++;
        if (test_errs == 0)
            $display("test %s ok", what);
        else
        begin
            $display("test %s failed", what);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // Same scan order as the clear, top row at address 0
    function automatic fb_frag_pkg::addr_t addr_of(input int x, input int y);
        return fb_frag_pkg::addr_t'((cur_yres - 1 - y) * cur_xres + x);
    endfunction

    //////////////////////////////////////////////////
    // Data file parsing
    //////////////////////////////////////////////////

    // Lines starting with # are skipped
    task automatic read_cmd(output bit got);
        string tok;
        string rest;
        int    n;
        bit    stop;
        got  = 1'b0;
        stop = 1'b0;
        while (!got && !stop)
        begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1)
                stop = 1'b1;
            else if (tok.substr(0, 0) == "#")
                n = $fgets(rest, fd);
            else
            begin
                cmd = tok;
                if (cmd == "CFG")
                    n = $fscanf(fd, "%s %d %d %h %d %d %d %d",
                                name, cfg_x, cfg_y, a_color, sx0, sy0, sx1, sy1);
                else if (cmd == "FRAG")
                    n = $fscanf(fd, "%s %d %d %h %d", name, a_x, a_y, a_color, a_strb);
                else if (cmd == "READ")
                    n = $fscanf(fd, "%s %d %d %h", name, a_x, a_y, a_color);
                else
                    n = $fscanf(fd, "%s", name);
                got = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    task automatic apply_cfg();
        @(negedge aclk);
        res_x       = fb_frag_pkg::xpos_t'(cfg_x);
        res_y       = fb_frag_pkg::ypos_t'(cfg_y);
        clear_color = a_color;
        scissor_x0  = fb_frag_pkg::xpos_t'(sx0);
        scissor_y0  = fb_frag_pkg::ypos_t'(sy0);
        scissor_x1  = fb_frag_pkg::xpos_t'(sx1);
        scissor_y1  = fb_frag_pkg::ypos_t'(sy1);
        cur_xres    = cfg_x;
        cur_yres    = cfg_y;
    endtask

    task automatic run_clear();
        int cycles;
        int limit;
        bit ready_high;
        limit        = cur_xres * cur_yres + 10;
        cycles       = 0;
        ready_high   = 1'b0;
        prev_read_ok = 1'b0;
        @(negedge aclk);
        clear_apply = 1'b1;
        @(negedge aclk);
        clear_apply = 1'b0;
        check_flag({name, " clear_done while busy"}, 1'b0, clear_done);
        // Pipeline must stay blocked for the whole scan
        while (!clear_done && cycles < limit)
        begin
            if (frag_ready)
                ready_high = 1'b1;
            @(negedge aclk);
            cycles++;
        end
        check_flag({name, " frag_ready seen during clear"}, 1'b0, ready_high);
        if (!clear_done)
            report_error($sformatf("%s did not finish within %0d cycles", name, limit));
        // Final write lands one edge later
        repeat (2) @(negedge aclk);
        end_test(name);
    endtask

    task automatic send_frag();
        int cycles;
        cycles       = 0;
        prev_read_ok = 1'b0;
        @(negedge aclk);
        frag_valid = 1'b1;
        frag_last  = 1'b0;
        frag_data  = a_color;
        frag_strb  = a_strb[0];
        frag_addr  = addr_of(a_x, a_y);
        frag_xpos  = fb_frag_pkg::xpos_t'(a_x);
        frag_ypos  = fb_frag_pkg::ypos_t'(a_y);
        while (!frag_ready && cycles < 100)
        begin
            @(negedge aclk);
            cycles++;
        end
        if (!frag_ready)
            report_error($sformatf("%s fragment never accepted", name));
        // Transfer on the rising edge in between
        @(negedge aclk);
        frag_valid = 1'b0;
        repeat (2) @(negedge aclk);
        end_test(name);
    endtask

    task automatic read_pixel();
        @(negedge aclk);
        rd_addr = addr_of(a_x, a_y);
        // Registered port still shows the old word before the rising edge
        if (prev_read_ok && prev_read !== a_color)
        begin
            #1;
            check_pixel({name, " before edge"}, prev_read, rd_data);
        end
        @(negedge aclk);
        check_pixel(name, a_color, rd_data);
        prev_read    = a_color;
        prev_read_ok = 1'b1;
        end_test(name);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    task automatic run_all();
        bit got;
        // First pass sizes the watchdog
        watch_cycles = 100;
        read_cmd(got);
        while (got)
        begin
            if (cmd == "CFG")
            begin
                cur_xres = cfg_x;
                cur_yres = cfg_y;
            end
            if (cmd == "CLEAR")
                watch_cycles += 4 * cur_xres * cur_yres;
            else
                watch_cycles += 100;
            read_cmd(got);
        end
        $fclose(fd);
        fd        = $fopen("fb_testdata.txt", "r");
        bound_set = 1'b1;
        // Reset held for two cycles
        repeat (2) @(negedge aclk);
        resetn = 1'b1;
        @(negedge aclk);
        check_flag("reset_state clear_done", 1'b1, clear_done);
        check_flag("reset_state frag_ready", 1'b1, frag_ready);
        end_test("reset_state");
        read_cmd(got);
        while (got)
        begin
            if (cmd == "CFG")
                apply_cfg();
            else if (cmd == "CLEAR")
                run_clear();
            else if (cmd == "FRAG")
                send_frag();
            else if (cmd == "READ")
                read_pixel();
            else
                report_error($sformatf("unknown command %s in data file", cmd));
            read_cmd(got);
        end
        $fclose(fd);
    endtask

    initial
    begin
        aclk         = 1'b0;
        resetn       = 1'b0;
        res_x        = '0;
        res_y        = '0;
        clear_color  = '0;
        scissor_x0   = '0;
        scissor_y0   = '0;
        scissor_x1   = '0;
        scissor_y1   = '0;
        clear_apply  = 1'b0;
        frag_valid   = 1'b0;
        frag_last    = 1'b0;
        frag_data    = '0;
        frag_strb    = 1'b0;
        frag_addr    = '0;
        frag_xpos    = '0;
        frag_ypos    = '0;
        rd_addr      = '0;
        prev_read    = '0;
        prev_read_ok = 1'b0;
        fd           = $fopen("fb_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR cannot open fb_testdata.txt");
            $display("RESULT: FAIL");
            $finish;
        end
        else
        begin
            run_all();
            $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                     tests_run, tests_run - tests_failed, tests_failed, err_count);
            if (tests_failed == 0 && err_count == 0)
                $display("RESULT: PASS");
            else
                $display("RESULT: FAIL");
            $finish;
        end
    end

    // Watchdog bound comes from the first pass over the data file
    initial
    begin
        wait (bound_set);
        repeat (watch_cycles) @(posedge aclk);
        $display("ERROR watchdog expired after %0d cycles", watch_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
